// ==== sim.f ====
logic/mem_pkg.sv
logic/bus_arbiter_fsm.sv
logic/request_latch.sv
logic/clint_timer.sv
logic/axi_lite_master.sv
logic/mem_interconnect.sv
testbench/axi_lite_mem_model.sv
testbench/tb_mem_interconnect.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run; the simulation log decides pass or fail.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_mem_interconnect \
    -f sim.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// ==== testbench/tb_mem_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_interconnect;

    localparam int             num_trans = 9;
    localparam mem_pkg::addr_t timer_lo  = mem_pkg::clint_base_default;
    localparam mem_pkg::addr_t timer_hi  = mem_pkg::clint_base_default + 32'd4;

    logic           clock;
    logic           reset;
    logic           fetch_req;
    mem_pkg::addr_t fetch_addr;
    mem_pkg::data_t fetch_rdata;
    mem_pkg::resp_t fetch_resp;
    logic           fetch_complete;
    logic           lsu_req;
    mem_pkg::addr_t lsu_addr;
    logic           lsu_wen;
    mem_pkg::data_t lsu_wdata;
    mem_pkg::strb_t lsu_wstrb;
    mem_pkg::data_t lsu_rdata;
    mem_pkg::resp_t lsu_resp;
    logic           lsu_complete;
    logic           awvalid, awready, wvalid, wready, bvalid, bready;
    logic           arvalid, arready, rvalid, rready;
    mem_pkg::addr_t awaddr, araddr;
    mem_pkg::data_t wdata, rdata;
    mem_pkg::strb_t wstrb;
    mem_pkg::resp_t bresp, rresp;

    mem_pkg::data_t fetch_exp;
    mem_pkg::data_t lsu_exp;
    mem_pkg::resp_t lsu_exp_resp;
    mem_pkg::data_t timer_first;
    logic           lsu_chk_data;
    logic           lsu_chk_rise; // second timer read.
    logic           clint_busy;
    logic           lsu_first;
    logic [31:0]    lsu_wait; // edges that saw the current lsu req.

    mem_interconnect #(
        .clint_base(mem_pkg::clint_base_default)
    ) dut (.*);

    axi_lite_mem_model u_mem (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    initial begin
        repeat (10 + 40 * num_trans) @(posedge clock);
        stop_run("timeout, a request never completed");
    end

    always @(posedge clock) begin
        if (reset || !lsu_req) begin
            lsu_wait <= '0;
        end else if (!lsu_complete) begin
            lsu_wait <= lsu_wait + 32'd1;
        end
    end

    a_quiet: assert property (@(posedge clock) reset |=> !(fetch_complete || lsu_complete ||
        awvalid || wvalid || arvalid || bready || rready))
        else stop_run("outputs not quiet after reset");
    a_fetch_data: assert property (@(posedge clock) disable iff (reset)
        fetch_complete |-> fetch_rdata == fetch_exp)
        else stop_run($sformatf("MISMATCH fetch_rdata got %h expected %h",
            $sampled(fetch_rdata), fetch_exp));
    a_fetch_resp: assert property (@(posedge clock) disable iff (reset)
        fetch_complete |-> fetch_resp == mem_pkg::resp_okay)
        else stop_run($sformatf("MISMATCH fetch_resp got %h expected %h",
            $sampled(fetch_resp), mem_pkg::resp_okay));
    a_lsu_data: assert property (@(posedge clock) disable iff (reset)
        lsu_complete && lsu_chk_data |-> lsu_rdata == lsu_exp)
        else stop_run($sformatf("MISMATCH lsu_rdata got %h expected %h",
            $sampled(lsu_rdata), lsu_exp));
    a_lsu_resp: assert property (@(posedge clock) disable iff (reset)
        lsu_complete |-> lsu_resp == lsu_exp_resp)
        else stop_run($sformatf("MISMATCH lsu_resp got %h expected %h",
            $sampled(lsu_resp), lsu_exp_resp));
    a_timer_rise: assert property (@(posedge clock) disable iff (reset)
        lsu_complete && lsu_chk_rise |-> lsu_rdata > timer_first)
        else stop_run($sformatf("MISMATCH lsu_rdata got %h expected above %h",
            $sampled(lsu_rdata), timer_first));
    // req sampled in idle, then capture, clint read, respond.
    a_timer_latency: assert property (@(posedge clock) disable iff (reset)
        lsu_complete && clint_busy && !lsu_wen |-> lsu_wait == 32'd3)
        else stop_run($sformatf("MISMATCH lsu_wait got %h expected %h",
            $sampled(lsu_wait), 32'd3));
    a_clint_no_axi: assert property (@(posedge clock) disable iff (reset)
        clint_busy |-> !(awvalid || wvalid || arvalid))
        else stop_run("AXI valid raised during a CLINT access");
    a_lsu_first: assert property (@(posedge clock) disable iff (reset)
        lsu_first && fetch_complete |-> !lsu_req)
        else stop_run("fetch completed while the lsu request was still waiting");
    a_aw_stable: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else stop_run("awvalid or awaddr changed before awready");
    a_w_stable: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else stop_run("wvalid or write data changed before wready");
    a_ar_stable: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else stop_run("arvalid or araddr changed before arready");

    // holds req until complete, then leaves one edge for the checks.
    task automatic lsu_access(input mem_pkg::addr_t addr, input logic wen,
                              input mem_pkg::data_t data, input mem_pkg::strb_t strb);
        lsu_addr = addr;
        lsu_wen = wen;
        lsu_wdata = data;
        lsu_wstrb = strb;
        lsu_req = 1'b1;
        do begin
            @(posedge clock);
            #1;
        end while (!lsu_complete);
        lsu_req = 1'b0;
        @(posedge clock);
        #1;
    endtask

    task automatic fetch_access(input mem_pkg::addr_t addr);
        fetch_addr = addr;
        fetch_req = 1'b1;
        do begin
            @(posedge clock);
            #1;
        end while (!fetch_complete);
        fetch_req = 1'b0;
        @(posedge clock);
        #1;
    endtask

    task automatic race_access(input mem_pkg::addr_t f_addr, input mem_pkg::addr_t l_addr);
        logic f_open;
        logic l_open;
        f_open = 1'b1;
        l_open = 1'b1;
        fetch_addr = f_addr;
        lsu_addr = l_addr;
        lsu_wen = 1'b0;
        fetch_req = 1'b1;
        lsu_req = 1'b1;
        while (f_open || l_open) begin
            @(posedge clock);
            #1;
            if (fetch_complete) begin
                fetch_req = 1'b0;
                f_open = 1'b0;
            end
            if (lsu_complete) begin
                lsu_req = 1'b0;
                l_open = 1'b0;
            end
        end
        @(posedge clock);
        #1;
    endtask

    initial begin
        reset = 1'b1;
        fetch_req = 1'b0;
        fetch_addr = '0;
        lsu_req = 1'b0;
        lsu_addr = '0;
        lsu_wen = 1'b0;
        lsu_wdata = '0;
        lsu_wstrb = '0;
        fetch_exp = '0;
        lsu_exp = '0;
        lsu_exp_resp = mem_pkg::resp_okay;
        timer_first = '0;
        lsu_chk_data = 1'b0;
        lsu_chk_rise = 1'b0;
        clint_busy = 1'b0;
        lsu_first = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        clint_busy = 1'b1;
        lsu_chk_data = 1'b1; // mtimeh still zero.
        lsu_access(timer_hi, 1'b0, '0, '0);
        lsu_chk_data = 1'b0;
        lsu_access(timer_lo, 1'b0, '0, '0);
        timer_first = lsu_rdata;
        lsu_chk_rise = 1'b1;
        lsu_access(timer_lo, 1'b0, '0, '0);
        lsu_chk_rise = 1'b0;
        lsu_exp_resp = mem_pkg::resp_slverr;
        lsu_access(timer_lo, 1'b1, 32'hdead_beef, 4'hf);
        lsu_exp_resp = mem_pkg::resp_okay;
        clint_busy = 1'b0;

        fetch_exp = ~32'h0000_0040;
        fetch_access(32'h0000_0040);

        lsu_access(32'h0000_0080, 1'b1, 32'h1234_5678, 4'b0101);
        // lanes 0 and 2 written, 1 and 3 keep the fill.
        lsu_exp = (~32'h0000_0080 & 32'hff00_ff00) | (32'h1234_5678 & 32'h00ff_00ff);
        lsu_chk_data = 1'b1;
        lsu_access(32'h0000_0080, 1'b0, '0, '0);

        fetch_exp = ~32'h0000_0100;
        lsu_exp = ~32'h0000_0200;
        lsu_first = 1'b1;
        race_access(32'h0000_0100, 32'h0000_0200);
        lsu_first = 1'b0;

        repeat (4) @(posedge clock);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/axi_lite_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_mem_model (
    input  logic           clock,
    input  logic           reset,
    input  logic           awvalid,
    input  mem_pkg::addr_t awaddr,
    input  logic           wvalid,
    input  mem_pkg::data_t wdata,
    input  mem_pkg::strb_t wstrb,
    input  logic           bready,
    input  logic           arvalid,
    input  mem_pkg::addr_t araddr,
    input  logic           rready,
    output logic           awready,
    output logic           wready,
    output logic           bvalid,
    output mem_pkg::resp_t bresp,
    output logic           arready,
    output logic           rvalid,
    output mem_pkg::data_t rdata,
    output mem_pkg::resp_t rresp
);

    mem_pkg::data_t mem [0:255];
    logic [31:0]    seed;
    logic [1:0]     aw_cnt, w_cnt, b_cnt, ar_cnt, r_cnt; // stall cycles left.
    logic           aw_rdy, w_rdy, b_vld, ar_rdy, r_vld;
    logic           aw_got, w_got, b_pend, r_pend;
    logic [7:0]     wr_idx;
    mem_pkg::data_t wr_data;
    mem_pkg::data_t rd_data;
    mem_pkg::strb_t wr_strb;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_stall(output logic [1:0] n);
        seed = lcg_next(seed);
        n = seed[31:30]; // upper bits, 0 to 3 cycles.
    endtask

    task automatic count_down(inout logic [1:0] cnt, output logic fire);
        fire = (cnt == 2'd0);
        if (!fire) begin
            cnt = cnt - 2'd1;
        end
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = ~(i * 4); // inverse of the byte address.
        end
        seed = 32'hb224;
        rd_data = '0;
        {awready, wready, bvalid, arready, rvalid} = '0;
        bresp = mem_pkg::resp_okay;
        rresp = mem_pkg::resp_okay;
        rdata = '0;
        forever begin
            @(posedge clock);
            if (reset) begin
                {aw_rdy, w_rdy, b_vld, ar_rdy, r_vld} = '0;
                {aw_got, w_got, b_pend, r_pend} = '0;
                draw_stall(aw_cnt);
                draw_stall(w_cnt);
                draw_stall(b_cnt);
                draw_stall(ar_cnt);
                draw_stall(r_cnt);
            end else begin
                if (awvalid && aw_rdy) begin
                    aw_rdy = 1'b0;
                    aw_got = 1'b1;
                    wr_idx = awaddr[9:2];
                    draw_stall(aw_cnt);
                end else if (awvalid) begin
                    count_down(aw_cnt, aw_rdy);
                end
                if (wvalid && w_rdy) begin
                    w_rdy = 1'b0;
                    w_got = 1'b1;
                    wr_data = wdata;
                    wr_strb = wstrb;
                    draw_stall(w_cnt);
                end else if (wvalid) begin
                    count_down(w_cnt, w_rdy);
                end
                if (aw_got && w_got) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wr_strb[i]) begin
                            mem[wr_idx][8*i +: 8] = wr_data[8*i +: 8]; // byte merge.
                        end
                    end
                    aw_got = 1'b0;
                    w_got = 1'b0;
                    b_pend = 1'b1;
                end
                if (b_vld && bready) begin
                    b_vld = 1'b0;
                    draw_stall(b_cnt);
                end else if (b_pend) begin
                    count_down(b_cnt, b_vld);
                    b_pend = !b_vld;
                end
                if (arvalid && ar_rdy) begin
                    ar_rdy = 1'b0;
                    rd_data = mem[araddr[9:2]];
                    r_pend = 1'b1;
                    draw_stall(ar_cnt);
                end else if (arvalid) begin
                    count_down(ar_cnt, ar_rdy);
                end
                if (r_vld && rready) begin
                    r_vld = 1'b0;
                    draw_stall(r_cnt);
                end else if (r_pend) begin
                    count_down(r_cnt, r_vld);
                    r_pend = !r_vld;
                end
            end
            #1;
            awready = aw_rdy;
            wready = w_rdy;
            bvalid = b_vld;
            arready = ar_rdy;
            rvalid = r_vld;
            rdata = rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_interconnect #(
    parameter mem_pkg::addr_t clint_base = mem_pkg::clint_base_default
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           fetch_req,
    input  mem_pkg::addr_t fetch_addr,
    output mem_pkg::data_t fetch_rdata,
    output mem_pkg::resp_t fetch_resp,
    output logic           fetch_complete,
    input  logic           lsu_req,
    input  mem_pkg::addr_t lsu_addr,
    input  logic           lsu_wen,
    input  mem_pkg::data_t lsu_wdata,
    input  mem_pkg::strb_t lsu_wstrb,
    output mem_pkg::data_t lsu_rdata,
    output mem_pkg::resp_t lsu_resp,
    output logic           lsu_complete,
    output logic           awvalid,
    input  logic           awready,
    output mem_pkg::addr_t awaddr,
    output logic           wvalid,
    input  logic           wready,
    output mem_pkg::data_t wdata,
    output mem_pkg::strb_t wstrb,
    input  logic           bvalid,
    output logic           bready,
    input  mem_pkg::resp_t bresp,
    output logic           arvalid,
    input  logic           arready,
    output mem_pkg::addr_t araddr,
    input  logic           rvalid,
    output logic           rready,
    input  mem_pkg::data_t rdata,
    input  mem_pkg::resp_t rresp
);

    logic            capture;
    mem_pkg::grant_t grant;
    logic            clint_start;
    logic            ext_start;
    logic            ext_write;
    logic            respond;
    logic            err_resp;
    logic            clint_done;
    mem_pkg::data_t  clint_rdata;
    logic            ext_done;
    mem_pkg::data_t  ext_rdata;
    mem_pkg::resp_t  ext_resp;
    mem_pkg::addr_t  req_addr; // granted request fields.
    mem_pkg::data_t  req_wdata;
    mem_pkg::strb_t  req_wstrb;

    bus_arbiter_fsm #(
        .clint_base(clint_base)
    ) u_arbiter (
        .clock, .reset,
        .fetch_req, .lsu_req, .lsu_addr, .fetch_addr, .lsu_wen,
        .clint_done, .ext_done,
        .capture, .grant, .clint_start, .ext_start, .ext_write,
        .respond, .err_resp
    );

    request_latch u_latch (
        .clock, .reset,
        .capture, .grant, .fetch_addr, .lsu_addr, .lsu_wdata, .lsu_wstrb,
        .respond, .err_resp,
        .clint_rdata, .clint_done, .ext_rdata, .ext_resp, .ext_done,
        .addr  (req_addr),
        .wdata (req_wdata),
        .wstrb (req_wstrb),
        .fetch_rdata, .fetch_resp, .fetch_complete,
        .lsu_rdata, .lsu_resp, .lsu_complete
    );

    clint_timer u_clint (
        .clock, .reset,
        .clint_start,
        .addr (req_addr),
        .clint_rdata, .clint_done
    );

    axi_lite_master u_axi (
        .clock, .reset,
        .ext_start, .ext_write,
        .addr      (req_addr),
        .wdata     (req_wdata),
        .wstrb     (req_wstrb),
        .awready, .wready, .bvalid, .bresp, .arready, .rvalid, .rdata, .rresp,
        .awvalid, .awaddr, .wvalid,
        .wdata_out (wdata),
        .wstrb_out (wstrb),
        .bready, .arvalid, .araddr, .rready,
        .ext_rdata, .ext_resp, .ext_done
    );

endmodule

`default_nettype wire

// ==== logic/axi_lite_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_master (
    input  logic           clock,
    input  logic           reset,
    input  logic           ext_start,
    input  logic           ext_write,
    input  mem_pkg::addr_t addr,
    input  mem_pkg::data_t wdata,
    input  mem_pkg::strb_t wstrb,
    input  logic           awready,
    input  logic           wready,
    input  logic           bvalid,
    input  mem_pkg::resp_t bresp,
    input  logic           arready,
    input  logic           rvalid,
    input  mem_pkg::data_t rdata,
    input  mem_pkg::resp_t rresp,
    output logic           awvalid,
    output mem_pkg::addr_t awaddr,
    output logic           wvalid,
    output mem_pkg::data_t wdata_out,
    output mem_pkg::strb_t wstrb_out,
    output logic           bready,
    output logic           arvalid,
    output mem_pkg::addr_t araddr,
    output logic           rready,
    output mem_pkg::data_t ext_rdata,
    output mem_pkg::resp_t ext_resp,
    output logic           ext_done
);

    mem_pkg::addr_t addr_q;
    logic           wr_busy; // write issued, b not yet taken.
    logic           aw_clear;
    logic           w_clear;
    logic           b_fire;
    logic           r_fire;

    assign aw_clear = !awvalid || awready;
    assign w_clear  = !wvalid || wready;
    assign b_fire   = bvalid && bready;
    assign r_fire   = rvalid && rready;

    always_ff @(posedge clock) begin
        if (reset) begin
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            bready   <= 1'b0;
            arvalid  <= 1'b0;
            rready   <= 1'b0;
            wr_busy  <= 1'b0;
            ext_done <= 1'b0;
        end else begin
            ext_done <= b_fire || r_fire;
            if (ext_start && ext_write) begin
                awvalid <= 1'b1; // aw and w go out together.
                wvalid  <= 1'b1;
                wr_busy <= 1'b1;
            end
            if (ext_start && !ext_write) begin
                arvalid <= 1'b1;
            end
            if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0;
            end
            if (wr_busy && !bready && aw_clear && w_clear) begin
                bready <= 1'b1; // both channels accepted.
            end
            if (b_fire) begin
                bready  <= 1'b0;
                wr_busy <= 1'b0;
            end
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            if (r_fire) begin
                rready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ext_start) begin
            addr_q    <= addr;
            wdata_out <= wdata;
            wstrb_out <= wstrb;
        end
        if (b_fire) begin
            ext_resp <= bresp;
        end
        if (r_fire) begin
            ext_rdata <= rdata;
            ext_resp  <= rresp;
        end
    end

    assign awaddr = addr_q;
    assign araddr = addr_q;

    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr));

    a_w_hold: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata_out) && $stable(wstrb_out));

    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

// ==== logic/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
    input  logic           clock,
    input  logic           reset,
    input  logic           clint_start,
    input  mem_pkg::addr_t addr,
    output mem_pkg::data_t clint_rdata,
    output logic           clint_done
);

    logic [63:0] mtime;

    always_ff @(posedge clock) begin
        if (reset) begin
            mtime      <= '0;
            clint_done <= 1'b0;
        end else begin
            mtime      <= mtime + 64'd1; // free running.
            clint_done <= clint_start;
        end
    end

    // word offset 4 selects mtimeh.
    always_ff @(posedge clock) begin
        if (clint_start) begin
            clint_rdata <= addr[2] ? mtime[63:32] : mtime[31:0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/request_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module request_latch (
    input  logic            clock,
    input  logic            reset,
    input  logic            capture,
    input  mem_pkg::grant_t grant,
    input  mem_pkg::addr_t  fetch_addr,
    input  mem_pkg::addr_t  lsu_addr,
    input  mem_pkg::data_t  lsu_wdata,
    input  mem_pkg::strb_t  lsu_wstrb,
    input  logic            respond,
    input  logic            err_resp,
    input  mem_pkg::data_t  clint_rdata,
    input  logic            clint_done,
    input  mem_pkg::data_t  ext_rdata,
    input  mem_pkg::resp_t  ext_resp,
    input  logic            ext_done,
    output mem_pkg::addr_t  addr,
    output mem_pkg::data_t  wdata,
    output mem_pkg::strb_t  wstrb,
    output mem_pkg::data_t  fetch_rdata,
    output mem_pkg::resp_t  fetch_resp,
    output logic            fetch_complete,
    output mem_pkg::data_t  lsu_rdata,
    output mem_pkg::resp_t  lsu_resp,
    output logic            lsu_complete
);

    mem_pkg::grant_t owner;
    mem_pkg::data_t  ret_data;
    mem_pkg::resp_t  ret_resp;

    always_comb begin
        ret_data = '0;
        ret_resp = mem_pkg::resp_okay;
        if (clint_done) begin
            ret_data = clint_rdata;
        end else if (ext_done) begin
            ret_data = ext_rdata;
            ret_resp = ext_resp;
        end
        if (err_resp) begin
            ret_resp = mem_pkg::resp_slverr;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            owner          <= mem_pkg::none;
            fetch_complete <= 1'b0;
            lsu_complete   <= 1'b0;
        end else begin
            if (capture) begin
                owner <= grant;
            end else if (respond) begin
                owner <= mem_pkg::none;
            end
            fetch_complete <= respond && (owner == mem_pkg::fetch);
            lsu_complete   <= respond && (owner == mem_pkg::lsu);
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            addr  <= (grant == mem_pkg::lsu) ? lsu_addr : fetch_addr;
            wdata <= lsu_wdata; // fetch ignores these.
            wstrb <= lsu_wstrb;
        end
        if (respond && (owner == mem_pkg::fetch)) begin
            fetch_rdata <= ret_data;
            fetch_resp  <= ret_resp;
        end
        if (respond && (owner == mem_pkg::lsu)) begin
            lsu_rdata <= ret_data;
            lsu_resp  <= ret_resp;
        end
    end

    // one owner per access, one complete per access.
    a_complete_excl: assert property (@(posedge clock) disable iff (reset)
        (fetch_complete || lsu_complete) |->
            !(fetch_complete && lsu_complete) ##1 !(fetch_complete || lsu_complete));

endmodule

`default_nettype wire

// ==== logic/bus_arbiter_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter_fsm #(
    parameter mem_pkg::addr_t clint_base = mem_pkg::clint_base_default
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            fetch_req,
    input  logic            lsu_req,
    input  mem_pkg::addr_t  lsu_addr,
    input  mem_pkg::addr_t  fetch_addr,
    input  logic            lsu_wen,
    input  logic            clint_done,
    input  logic            ext_done,
    output logic            capture,
    output mem_pkg::grant_t grant,
    output logic            clint_start,
    output logic            ext_start,
    output logic            ext_write,
    output logic            respond,
    output logic            err_resp
);

    mem_pkg::arb_state_t state;
    mem_pkg::arb_state_t state_next;
    mem_pkg::addr_t      sel_addr;
    logic                sel_write;
    logic                sel_clint;
    logic                settle; // complete is out, req still stale.
    logic                err_flag;

    assign sel_addr  = lsu_req ? lsu_addr : fetch_addr; // lsu has priority.
    assign sel_write = lsu_req && lsu_wen;
    assign sel_clint = (sel_addr >= clint_base) &&
                       ((sel_addr - clint_base) < mem_pkg::clint_size);

    assign capture = (state == mem_pkg::idle) && !settle && (lsu_req || fetch_req);

    always_comb begin
        grant = mem_pkg::none;
        if (capture && lsu_req) begin
            grant = mem_pkg::lsu;
        end else if (capture) begin
            grant = mem_pkg::fetch;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            mem_pkg::idle: begin
                if (capture && sel_clint) begin
                    state_next = sel_write ? mem_pkg::respond : mem_pkg::clint_access;
                end else if (capture) begin
                    state_next = sel_write ? mem_pkg::ext_write : mem_pkg::ext_read;
                end
            end
            mem_pkg::clint_access: state_next = mem_pkg::respond;
            mem_pkg::ext_read:     state_next = mem_pkg::respond;
            mem_pkg::ext_write:    state_next = mem_pkg::respond;
            mem_pkg::respond: begin
                if (respond) begin
                    state_next = mem_pkg::idle;
                end
            end
            default: state_next = mem_pkg::idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= mem_pkg::idle;
            settle   <= 1'b0;
            err_flag <= 1'b0;
        end else begin
            state  <= state_next;
            settle <= respond;
            if (capture) begin
                err_flag <= sel_clint && sel_write; // timer is read only.
            end
        end
    end

    assign clint_start = (state == mem_pkg::clint_access);
    assign ext_start   = (state == mem_pkg::ext_read) || (state == mem_pkg::ext_write);
    assign ext_write   = (state == mem_pkg::ext_write);
    // waits here for the data source.
    assign respond     = (state == mem_pkg::respond) && (err_flag || clint_done || ext_done);
    assign err_resp    = (state == mem_pkg::respond) && err_flag;

    // no response still pending at a new grant.
    a_capture_clean: assert property (@(posedge clock) disable iff (reset)
        capture |-> !(clint_done || ext_done));

    a_respond_pulse: assert property (@(posedge clock) disable iff (reset)
        respond |=> !(clint_done || ext_done));

endmodule

`default_nettype wire

// ==== logic/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    typedef logic [31:0] addr_t; // byte address.
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t; // one bit per byte lane.
    typedef logic [1:0]  resp_t;

    localparam resp_t resp_okay   = 2'd0;
    localparam resp_t resp_slverr = 2'd2;

    // access sequencing of the shared bus.
    typedef enum logic [2:0] {
        idle,
        clint_access,
        ext_read,
        ext_write,
        respond
    } arb_state_t;

    // requester that owns the access in flight.
    typedef enum logic [1:0] {
        none,
        fetch,
        lsu
    } grant_t;

    localparam addr_t clint_base_default = 32'h0200_0000;
    localparam addr_t clint_size         = 32'h0001_0000; // whole timer window.

endpackage

`default_nettype wire
